//--- source/qsgmii_pkg.sv
package qsgmii_pkg;

	//////////////////////////////
	// Port count

	// Four SGMII ports share one QSGMII lane
	localparam int num_ports = 4;

	//////////////////////////////
	// Code groups

	// Comma that opens idle and configuration ordered sets
	localparam logic [7:0] k28_5 = 8'hbc;

	// Comma variant that marks lane zero on the wire
	localparam logic [7:0] k28_1 = 8'h3c;

	// Start of packet
	localparam logic [7:0] k27_7 = 8'hfb;

	// End of packet
	localparam logic [7:0] k29_7 = 8'hfd;

	// Second byte of /C1/ and /C2/
	localparam logic [7:0] d21_5 = 8'hb5;
	localparam logic [7:0] d2_2 = 8'h42;

	// GMII replaces /S/ with a preamble byte
	localparam logic [7:0] preamble_byte = 8'h55;

	//////////////////////////////
	// Synchronization thresholds

	// Clean commas in a row before a port is declared in sync
	localparam int sync_acquire_commas = 3;

	// Errored code groups in a row before sync is dropped
	localparam int sync_loss_errors = 4;

	//////////////////////////////
	// SGMII configuration word

	// Field layout as sent by the PHY side of an SGMII link
	typedef struct packed {
		logic link_up;
		logic ack;
		logic reserved_hi;
		logic full_duplex;
		logic [1:0] speed;			// 0 = 10M, 1 = 100M, 2 = 1000M
		logic [8:0] reserved_lo;
		logic sgmii_mode;
	} sgmii_config_fields_t;

	// Built as raw bytes, read back as fields
	typedef union packed {
		logic [15:0] raw;
		sgmii_config_fields_t fields;
	} sgmii_config_word_t;

endpackage

//--- source/qsgmii_lane_splitter.sv
`timescale 1ns/1ps

module qsgmii_lane_splitter import qsgmii_pkg::*; (
	input logic rx_clk,
	input logic rst_n,

	// Raw transceiver word, four code groups wide
	input logic rx_data_valid,
	input logic [num_ports-1:0] rx_data_is_ctl,
	input logic [num_ports*8-1:0] rx_data,
	input logic [num_ports-1:0] rx_disparity_err,
	input logic [num_ports-1:0] rx_symbol_err,

	// Same word with byte i belonging to port i
	output logic lane_valid,
	output logic [num_ports-1:0] lane_is_ctl,
	output logic [num_ports*8-1:0] lane_data,
	output logic [num_ports-1:0] lane_err
);

	//////////////////////////////
	// Lane rotation

	// Input lane that currently carries port zero
	logic [1:0] base_lane;
	logic [1:0] next_base;

	// Source lane for every output byte
	logic [1:0] src_lane [num_ports];

	// Rotated word before the output register
	logic [num_ports-1:0] map_is_ctl;
	logic [num_ports*8-1:0] map_data;
	logic [num_ports-1:0] map_err;

	always_comb begin
		next_base = base_lane;
		for (int i = 0; i < num_ports; i++) begin
			// Two-bit add wraps around the four lanes
			src_lane[i] = 2'(i) + base_lane;

			map_is_ctl[i] = rx_data_is_ctl[src_lane[i]];
			map_data[i*8 +: 8] = rx_data[src_lane[i]*8 +: 8];

			// Both error kinds follow their own lane
			map_err[i] = rx_disparity_err[src_lane[i]] | rx_symbol_err[src_lane[i]];

			// K28.1 names lane zero
			// It is really a K28.5 as far as the port is concerned
			if (rx_data_valid && rx_data_is_ctl[src_lane[i]] &&
				(rx_data[src_lane[i]*8 +: 8] == k28_1)) begin
				map_data[i*8 +: 8] = k28_5;
				next_base = src_lane[i];
			end
		end
	end

	//////////////////////////////
	// Output register

	// New base applies from the following word
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			base_lane <= 2'd0;
			lane_valid <= 1'b0;
		end else begin
			base_lane <= next_base;
			lane_valid <= rx_data_valid;
		end
	end

	// Data moves every cycle, valid or not
	always_ff @(posedge rx_clk) begin
		lane_is_ctl <= map_is_ctl;
		lane_data <= map_data;
		lane_err <= map_err;
	end

endmodule

//--- source/sgmii_rx_sync.sv
`timescale 1ns/1ps

module sgmii_rx_sync import qsgmii_pkg::*; (
	input logic rx_clk,
	input logic rst_n,

	// One code group from the splitter
	input logic in_valid,
	input logic in_is_ctl,
	input logic [7:0] in_data,
	input logic in_err,

	// Same code group one cycle later
	output logic byte_valid,
	output logic byte_is_ctl,
	output logic [7:0] byte_data,
	output logic byte_err,

	// Port is in code-group sync
	output logic code_sync
);

	//////////////////////////////
	// Counters

	// Clean commas seen since the last bad code group
	logic [1:0] comma_cnt;

	// Bad code groups in a row while in sync
	logic [1:0] err_cnt;

	// Error-free K28.5
	logic is_comma;

	assign is_comma = in_is_ctl && (in_data == k28_5) && !in_err;

	//////////////////////////////
	// Sync state machine

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			code_sync <= 1'b0;
			comma_cnt <= 2'd0;
			err_cnt <= 2'd0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= in_valid;

			if (in_valid) begin
				if (!code_sync) begin
					// Hunting for commas
					if (in_err) begin
						comma_cnt <= 2'd0;
					end else if (is_comma) begin
						if (comma_cnt == 2'(sync_acquire_commas - 1)) begin
							code_sync <= 1'b1;
							comma_cnt <= 2'd0;
							err_cnt <= 2'd0;
						end else begin
							comma_cnt <= comma_cnt + 2'd1;
						end
					end
				end else begin
					// Locked, watch for a run of errors
					if (in_err) begin
						if (err_cnt == 2'(sync_loss_errors - 1)) begin
							code_sync <= 1'b0;
							err_cnt <= 2'd0;
							comma_cnt <= 2'd0;
						end else begin
							err_cnt <= err_cnt + 2'd1;
						end
					end else begin
						// Any good code group breaks the run
						err_cnt <= 2'd0;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Byte pipeline

	always_ff @(posedge rx_clk) begin
		byte_is_ctl <= in_is_ctl;
		byte_data <= in_data;
		byte_err <= in_err;
	end

endmodule

//--- source/sgmii_rx_decoder.sv
`timescale 1ns/1ps

module sgmii_rx_decoder import qsgmii_pkg::*; (
	input logic rx_clk,
	input logic rst_n,

	// Code group stream for one port
	input logic byte_valid,
	input logic byte_is_ctl,
	input logic [7:0] byte_data,
	input logic byte_err,
	input logic code_sync,

	// GMII receive side
	output logic gmii_rx_dv,
	output logic [7:0] gmii_rxd,
	output logic gmii_rx_er,

	// Accepted link partner configuration
	output logic [15:0] cfg_word,
	output logic cfg_update
);

	//////////////////////////////
	// Ordered set parser

	typedef enum logic [2:0] {
		st_idle,
		st_comma,
		st_cfg_lo,
		st_cfg_hi,
		st_packet
	} dec_state_t;

	dec_state_t state;

	// Low byte of the configuration set in flight
	logic [7:0] cfg_lo;

	// Word from the previous /C/ set, needed for the match rule
	logic [15:0] cfg_prev;
	logic [15:0] cfg_rx;

	logic is_comma;
	logic is_cfg_start;
	logic start_pkt;

	assign is_comma = byte_is_ctl && (byte_data == k28_5) && !byte_err;
	assign is_cfg_start = !byte_is_ctl && !byte_err &&
		((byte_data == d21_5) || (byte_data == d2_2));

	// /S/ only counts between ordered sets
	assign start_pkt = byte_valid && code_sync && byte_is_ctl && !byte_err &&
		(byte_data == k27_7) && ((state == st_idle) || (state == st_comma));

	// Config word arrives low byte first
	assign cfg_rx = {byte_data, cfg_lo};

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			gmii_rx_dv <= 1'b0;
			gmii_rx_er <= 1'b0;
			cfg_word <= 16'h0000;
			cfg_prev <= 16'h0000;
			cfg_update <= 1'b0;
		end else begin
			cfg_update <= 1'b0;
			gmii_rx_dv <= 1'b0;
			gmii_rx_er <= 1'b0;

			if (!code_sync) begin
				// Sync lost mid-frame, flag the byte that was cut
				if (byte_valid && (state == st_packet)) begin
					gmii_rx_dv <= 1'b1;
					gmii_rx_er <= 1'b1;
				end
				// Forget the partner so it is accepted again on relock
				state <= st_idle;
				cfg_word <= 16'h0000;
				cfg_prev <= 16'h0000;
			end else if (byte_valid) begin
				case (state)
					st_idle, st_comma: begin
						if (start_pkt) begin
							state <= st_packet;
							gmii_rx_dv <= 1'b1;
						end else if (is_comma) begin
							state <= st_comma;
						end else if ((state == st_comma) && is_cfg_start) begin
							state <= st_cfg_lo;
						end else begin
							state <= st_idle;
						end
					end

					st_cfg_lo: begin
						// Control or bad data aborts the set
						if (byte_is_ctl || byte_err)
							state <= is_comma ? st_comma : st_idle;
						else
							state <= st_cfg_hi;
					end

					st_cfg_hi: begin
						if (byte_is_ctl || byte_err) begin
							state <= is_comma ? st_comma : st_idle;
						end else begin
							state <= st_idle;
							cfg_prev <= cfg_rx;
							// Two matching copies in a row, and something new
							if ((cfg_rx == cfg_prev) && (cfg_rx != cfg_word)) begin
								cfg_word <= cfg_rx;
								cfg_update <= 1'b1;
							end
						end
					end

					st_packet: begin
						if (is_comma) begin
							// Frame ended without /T/
							gmii_rx_dv <= 1'b1;
							gmii_rx_er <= 1'b1;
							state <= st_comma;
						end else if (byte_is_ctl && !byte_err && (byte_data == k29_7)) begin
							state <= st_idle;
						end else begin
							gmii_rx_dv <= 1'b1;
							gmii_rx_er <= byte_err | byte_is_ctl;
						end
					end

					default: state <= st_idle;
				endcase
			end
		end
	end

	//////////////////////////////
	// Data path

	always_ff @(posedge rx_clk) begin
		gmii_rxd <= start_pkt ? preamble_byte : byte_data;
		if (byte_valid && (state == st_cfg_lo))
			cfg_lo <= byte_data;
	end

endmodule

//--- source/qsgmii_rx_top.sv
`timescale 1ns/1ps

module qsgmii_rx_top import qsgmii_pkg::*; (
	input logic rx_clk,
	input logic rst_n,

	// Transceiver receive word
	input logic rx_data_valid,
	input logic [num_ports-1:0] rx_data_is_ctl,
	input logic [num_ports*8-1:0] rx_data,
	input logic [num_ports-1:0] rx_disparity_err,
	input logic [num_ports-1:0] rx_symbol_err,

	// GMII receive, one byte lane per port
	output logic [num_ports-1:0] gmii_rx_dv,
	output logic [num_ports*8-1:0] gmii_rxd,
	output logic [num_ports-1:0] gmii_rx_er,

	// Port status
	output logic [num_ports-1:0] code_sync,
	output logic [num_ports-1:0] link_up,
	output logic [num_ports-1:0] full_duplex,
	output logic [num_ports*2-1:0] link_speed,
	output logic [num_ports-1:0] cfg_valid
);

	//////////////////////////////
	// Lane alignment

	logic lane_valid;
	logic [num_ports-1:0] lane_is_ctl;
	logic [num_ports*8-1:0] lane_data;
	logic [num_ports-1:0] lane_err;

	qsgmii_lane_splitter qsgmii_lane_splitter_inst (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.rx_data_valid(rx_data_valid),
		.rx_data_is_ctl(rx_data_is_ctl),
		.rx_data(rx_data),
		.rx_disparity_err(rx_disparity_err),
		.rx_symbol_err(rx_symbol_err),
		.lane_valid(lane_valid),
		.lane_is_ctl(lane_is_ctl),
		.lane_data(lane_data),
		.lane_err(lane_err)
	);

	//////////////////////////////
	// Per-port receive chains

	// Sync to decoder
	logic [num_ports-1:0] byte_valid;
	logic [num_ports-1:0] byte_is_ctl;
	logic [num_ports*8-1:0] byte_data;
	logic [num_ports-1:0] byte_err;

	// Decoder configuration outputs
	logic [num_ports*16-1:0] cfg_word;
	logic [num_ports-1:0] cfg_update;

	for (genvar p = 0; p < num_ports; p++) begin : g_port
		// Last accepted word, kept across loss of sync
		sgmii_config_word_t cfg_held;
		// Word shown on the outputs
		sgmii_config_word_t cfg_now;
		logic cfg_valid_q;

		sgmii_rx_sync sgmii_rx_sync_inst (
			.rx_clk(rx_clk),
			.rst_n(rst_n),
			.in_valid(lane_valid),
			.in_is_ctl(lane_is_ctl[p]),
			.in_data(lane_data[p*8 +: 8]),
			.in_err(lane_err[p]),
			.byte_valid(byte_valid[p]),
			.byte_is_ctl(byte_is_ctl[p]),
			.byte_data(byte_data[p*8 +: 8]),
			.byte_err(byte_err[p]),
			.code_sync(code_sync[p])
		);

		sgmii_rx_decoder sgmii_rx_decoder_inst (
			.rx_clk(rx_clk),
			.rst_n(rst_n),
			.byte_valid(byte_valid[p]),
			.byte_is_ctl(byte_is_ctl[p]),
			.byte_data(byte_data[p*8 +: 8]),
			.byte_err(byte_err[p]),
			.code_sync(code_sync[p]),
			.gmii_rx_dv(gmii_rx_dv[p]),
			.gmii_rxd(gmii_rxd[p*8 +: 8]),
			.gmii_rx_er(gmii_rx_er[p]),
			.cfg_word(cfg_word[p*16 +: 16]),
			.cfg_update(cfg_update[p])
		);

		// Hold the accepted word, cfg_valid drops with sync
		always_ff @(posedge rx_clk or negedge rst_n) begin
			if (!rst_n) begin
				cfg_held.raw <= 16'h0000;
				cfg_valid_q <= 1'b0;
			end else begin
				if (cfg_update[p])
					cfg_held.raw <= cfg_word[p*16 +: 16];

				if (!code_sync[p])
					cfg_valid_q <= 1'b0;
				else if (cfg_update[p])
					cfg_valid_q <= 1'b1;
			end
		end

		// Forward the fresh word so status adds no cycle
		assign cfg_now.raw = cfg_update[p] ? cfg_word[p*16 +: 16] : cfg_held.raw;

		assign link_up[p] = cfg_now.fields.link_up;
		assign full_duplex[p] = cfg_now.fields.full_duplex;
		assign link_speed[p*2 +: 2] = cfg_now.fields.speed;
		assign cfg_valid[p] = cfg_valid_q | cfg_update[p];
	end

endmodule

//--- tb/qsgmii_rx_tb.sv
`timescale 1ns/1ps

module qsgmii_rx_tb import qsgmii_pkg::*; ();

	// Data byte of the /I2/ idle ordered set
	localparam logic [7:0] d16_2 = 8'h50;
	// Reset plus all test words with a twofold margin
	localparam int run_cycles = 8 + 160;
	localparam int watchdog_ns = run_cycles * 20 * 2;

	logic rx_clk;
	logic rst_n;
	logic rx_data_valid;
	logic [3:0] rx_data_is_ctl;
	logic [31:0] rx_data;
	logic [3:0] rx_disparity_err;
	logic [3:0] rx_symbol_err;
	logic [3:0] gmii_rx_dv;
	logic [31:0] gmii_rxd;
	logic [3:0] gmii_rx_er;
	logic [3:0] code_sync;
	logic [3:0] link_up;
	logic [3:0] full_duplex;
	logic [7:0] link_speed;
	logic [3:0] cfg_valid;

	// Input lane that carries port zero
	int lane_zero;
	logic [31:0] rng_state = 32'hdaa3;

	// Expected GMII outputs with one entry per word in flight
	logic [3:0] exp_dv_q[$];
	logic [31:0] exp_rxd_q[$];
	logic [3:0] exp_er_q[$];
	// Ports whose gmii_rxd byte is compared
	logic [3:0] exp_mask_q[$];

	qsgmii_rx_top qsgmii_rx_top_inst (.*);

	//////////////////////////////
	// Clock and watchdog

	initial begin
		rx_clk = 1'b0;
		forever #10 rx_clk = ~rx_clk;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish in time");
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired");
	end

	//////////////////////////////
	// Helpers

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// SGMII word from its fields with sgmii_mode set
	function automatic logic [15:0] cfg_bits(input logic link, input logic fd,
		input logic [1:0] speed);
		return {link, 2'b00, fd, speed, 9'd0, 1'b1};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "Stopped at the first failed check");
		end
	endtask

	// Drives one transceiver word given per port
	// Checks the outputs for the word sent three cycles earlier
	task automatic word(input logic [3:0] ctl, input logic [31:0] data, input logic [3:0] serr,
		input logic [3:0] edv, input logic [31:0] erxd, input logic [3:0] eer,
		input logic [3:0] rmask);
		logic [31:0] bmask;
		logic [3:0] m;
		int l;
		@(posedge rx_clk);
		#1;
		if (exp_dv_q.size() == 3) begin
			m = exp_mask_q.pop_front();
			bmask = 32'h0;
			for (int p = 0; p < 4; p++) begin
				if (m[p])
					bmask[p*8 +: 8] = 8'hff;
			end
			check(gmii_rx_dv, exp_dv_q.pop_front(), "gmii_rx_dv");
			check(gmii_rx_er, exp_er_q.pop_front(), "gmii_rx_er");
			check(gmii_rxd & bmask, exp_rxd_q.pop_front() & bmask, "gmii_rxd");
		end
		// Port p rides on input lane p plus lane_zero
		for (int p = 0; p < 4; p++) begin
			l = (p + lane_zero) % 4;
			rx_data_is_ctl[l] = ctl[p];
			rx_data[l*8 +: 8] = data[p*8 +: 8];
			rx_symbol_err[l] = serr[p];
		end
		rx_data_valid = 1'b1;
		exp_dv_q.push_back(edv);
		exp_rxd_q.push_back(erxd);
		exp_er_q.push_back(eer);
		exp_mask_q.push_back(rmask);
	endtask

	task automatic idle_words(input int n);
		repeat (n) word(4'h0, {4{d16_2}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
	endtask

	// Plain /I/ sets with K28.5 on every port
	task automatic idle_sets(input int n);
		repeat (n) begin
			word(4'hf, {4{k28_5}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
			word(4'h0, {4{d16_2}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		end
	endtask

	// Four /I/ sets with the port zero comma sent as K28.1 in input lane k
	task automatic sync_ports(input int k);
		lane_zero = k;
		repeat (4) begin
			word(4'hf, {k28_5, k28_5, k28_5, k28_1}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
			word(4'h0, {4{d16_2}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		end
	endtask

	// One /C1/ set on the ports in m and /I/ sets on the rest
	task automatic cfg_set(input logic [3:0] m, input logic [63:0] w);
		logic [31:0] pre;
		logic [31:0] lo;
		logic [31:0] hi;
		for (int p = 0; p < 4; p++) begin
			pre[p*8 +: 8] = m[p] ? d21_5 : d16_2;
			lo[p*8 +: 8] = m[p] ? w[p*16 +: 8] : k28_5;
			hi[p*8 +: 8] = m[p] ? w[p*16+8 +: 8] : d16_2;
		end
		word(4'hf, {4{k28_5}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		word(4'h0, pre, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		word(~m, lo, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		word(4'h0, hi, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		// Status settles three cycles after the high byte
		idle_words(3);
	endtask

	//////////////////////////////
	// Tests

	task automatic test_lane_alignment(input int k);
		logic [31:0] bytes;
		sync_ports(k);
		for (int j = 0; j < 4; j++) begin
			bytes = 32'h04030201 + j * 32'h10101010;
			word(4'h0, bytes, 4'h0, 4'h0, bytes, 4'h0, 4'hf);
		end
		idle_words(3);
		check(code_sync, 4'hf, "code_sync after lane alignment");
	endtask

	task automatic test_packet();
		logic [31:0] payload;
		sync_ports(2);
		word(4'hf, {4{k27_7}}, 4'h0, 4'hf, {4{preamble_byte}}, 4'h0, 4'hf);
		repeat (20) begin
			payload = next_random();
			word(4'h0, payload, 4'h0, 4'hf, payload, 4'h0, 4'hf);
		end
		word(4'hf, {4{k29_7}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		idle_words(3);
	endtask

	// Symbol error on port one and a stray K23.7 on port three
	task automatic test_packet_errors();
		logic [31:0] payload;
		logic [3:0] ctl;
		logic [3:0] serr;
		logic [3:0] eer;
		sync_ports(1);
		word(4'hf, {4{k27_7}}, 4'h0, 4'hf, {4{preamble_byte}}, 4'h0, 4'hf);
		for (int j = 0; j < 6; j++) begin
			payload = next_random();
			ctl = 4'h0;
			serr = 4'h0;
			eer = 4'h0;
			if (j == 1) begin
				serr = 4'b0010;
				eer = 4'b0010;
			end
			if (j == 3) begin
				ctl = 4'b1000;
				payload[31:24] = 8'hf7;
				eer = 4'b1000;
			end
			word(ctl, payload, serr, 4'hf, payload, eer, 4'hf);
		end
		word(4'hf, {4{k29_7}}, 4'h0, 4'h0, 32'h0, 4'h0, 4'h0);
		idle_words(3);
	endtask

	task automatic test_config();
		logic [63:0] words;
		words = {16'h0, cfg_bits(1'b1, 1'b1, 2'd2), 16'h0, cfg_bits(1'b1, 1'b0, 2'd1)};
		sync_ports(0);
		cfg_set(4'b0101, words);
		check(cfg_valid, 4'h0, "cfg_valid after a single copy");
		cfg_set(4'b0101, words);
		check(cfg_valid, 4'b0101, "cfg_valid after two copies");
		check(link_up, 4'b0101, "link_up");
		check(full_duplex, 4'b0100, "full_duplex");
		check(link_speed, 8'h21, "link_speed");
		// An odd copy on port two leaves the accepted word alone
		cfg_set(4'b0100, {16'h0, cfg_bits(1'b0, 1'b0, 2'd0), 32'h0});
		check(cfg_valid, 4'b0101, "cfg_valid after an odd copy");
		check(link_up, 4'b0101, "link_up after an odd copy");
		check(full_duplex, 4'b0100, "full_duplex after an odd copy");
		check(link_speed, 8'h21, "link_speed after an odd copy");
	endtask

	task automatic test_sync_loss();
		logic [63:0] words;
		words = {32'h0, cfg_bits(1'b1, 1'b1, 2'd1), 16'h0};
		sync_ports(0);
		cfg_set(4'b0010, words);
		cfg_set(4'b0010, words);
		check(cfg_valid, 4'b0111, "cfg_valid before sync loss");
		// Three errors and then clean idles keep port one locked
		repeat (3) word(4'h0, {4{d16_2}}, 4'b0010, 4'h0, 32'h0, 4'h0, 4'h0);
		idle_words(3);
		check(code_sync, 4'hf, "code_sync after three errors on port one");
		repeat (4) word(4'h0, {4{d16_2}}, 4'b0010, 4'h0, 32'h0, 4'h0, 4'h0);
		idle_words(3);
		check(code_sync, 4'b1101, "code_sync after four errors on port one");
		check(cfg_valid, 4'b0101, "cfg_valid after sync loss");
		// Two commas are one short of relock
		idle_sets(2);
		idle_words(3);
		check(code_sync, 4'b1101, "code_sync after two commas on port one");
		// Third comma brings port one back
		// Its configuration stays invalid
		idle_sets(1);
		idle_words(3);
		check(code_sync, 4'hf, "code_sync after three commas on port one");
		check(cfg_valid, 4'b0101, "cfg_valid after regain");
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		rst_n = 1'b0;
		rx_data_valid = 1'b0;
		rx_data_is_ctl = 4'h0;
		rx_data = 32'h0;
		rx_disparity_err = 4'h0;
		rx_symbol_err = 4'h0;
		lane_zero = 0;
		repeat (8) @(posedge rx_clk);
		#1;
		rst_n = 1'b1;
		test_lane_alignment(3);
		test_lane_alignment(1);
		test_packet();
		test_packet_errors();
		test_config();
		test_sync_loss();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- list.f
source/qsgmii_pkg.sv
source/qsgmii_lane_splitter.sv
source/sgmii_rx_sync.sv
source/sgmii_rx_decoder.sv
source/qsgmii_rx_top.sv
tb/qsgmii_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= qsgmii_rx_tb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
